// File: source/mem_pkg.sv
// ------------------------------------------------------------
// word, address and bus types of the processor memory side
// processor data and address are both one 16-bit word
// cpu requests hold valid until a one-cycle ready pulse
// ------------------------------------------------------------
`default_nettype none

package mem_pkg;

	// data and processor address width
	localparam int unsigned word_bits = 16;

	typedef logic [word_bits - 1 : 0] t_word;
	typedef logic [word_bits - 1 : 0] t_addr;

	// processor request, fields stable while valid is high
	typedef struct packed {
		logic valid;
		logic write;
		t_addr addr;
		t_word wdata;
	} t_cpu_req;

	// rdata only meaningful with ready
	typedef struct packed {
		logic ready;
		t_word rdata;
	} t_cpu_rsp;

	// ram port 1 request, address is cut to the ram depth inside the ram
	typedef struct packed {
		logic write_en;
		t_addr addr;
		t_word wdata;
	} t_ram_port;

	// counter width for a given number of words, at least one bit
	function automatic int unsigned index_bits(input int unsigned words);
		return (words > 1) ? $clog2(words) : 1;
	endfunction

endpackage

`default_nettype wire

// File: source/ctrl_pkg.sv
// ------------------------------------------------------------
// state encodings of the boot sequencer and access controller
// ------------------------------------------------------------
`default_nettype none

package ctrl_pkg;

	// ------------------------------------------------------------
	// boot sequencer
	// ------------------------------------------------------------
	// reset, copy rom into ram, then hand ram to the cpu
	typedef enum logic [1 : 0] {
		RESET_ALL,
		COPY_ROM,
		RUN_CPU
	} t_boot_state;

	// ------------------------------------------------------------
	// memory access controller
	// ------------------------------------------------------------
	// idle, read wait + ready, data latch, ram write
	typedef enum logic [1 : 0] {
		WAIT_MEM,
		MEM_READY,
		PREPARE_WRITE,
		MEM_WRITE
	} t_access_state;

endpackage

`default_nettype wire

// File: source/rom_image.sv
// ------------------------------------------------------------
// program rom, purely combinational
// word i = (i * 0x0101) ^ 0xa500, stands in for a real image
// indices at or above rom_words read as zero
// ------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rom_image #(
	parameter int unsigned rom_words = 32
) (
	input wire logic [mem_pkg::index_bits(rom_words) - 1 : 0] rom_index,
	output mem_pkg::t_word rom_word
);

	// rule for one rom word
	function automatic mem_pkg::t_word rom_rule(input int unsigned index);
		mem_pkg::t_word base;
		base = mem_pkg::t_word'(index);
		return (base * 16'h0101) ^ 16'ha500;
	endfunction

	always_comb begin
		if (int'(rom_index) < rom_words)
			rom_word = rom_rule(int'(rom_index));
		else
			// outside the image
			rom_word = '0;
	end

endmodule

`default_nettype wire

// File: source/ram_2port.sv
// ------------------------------------------------------------
// dual-port ram, 2**ram_addr_bits words, one-cycle read latency
// port 1 read/write, read returns the old word on a write
// port 2 read only
// higher address bits on port 1 are ignored, so addresses alias
// ------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ram_2port #(
	parameter int unsigned ram_addr_bits = 9
) (
	input wire logic clock,

	// port 1
	input mem_pkg::t_ram_port port1,
	output mem_pkg::t_word port1_rdata,

	// port 2
	input wire logic [ram_addr_bits - 1 : 0] port2_addr,
	output mem_pkg::t_word port2_rdata
);

	mem_pkg::t_word mem [2 ** ram_addr_bits];

	logic [ram_addr_bits - 1 : 0] port1_addr;
	assign port1_addr = port1.addr[ram_addr_bits - 1 : 0];

	// port 1, read before write
	always_ff @(posedge clock) begin
		if (port1.write_en)
			mem[port1_addr] <= port1.wdata;
		port1_rdata <= mem[port1_addr];
	end

	// port 2
	always_ff @(posedge clock) begin
		port2_rdata <= mem[port2_addr];
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	// high from the second clock on
	logic past_first_clock = 1'b0;
	always_ff @(posedge clock) begin
		past_first_clock <= 1'b1;
	end

	// write enable comes from the boot mux and the access fsm
	a_write_en_known: assert property (@(posedge clock)
		past_first_clock |-> !$isunknown(port1.write_en));

endmodule

`default_nettype wire

// File: source/boot_sequencer.sv
// ------------------------------------------------------------
// boot sequencer, copies rom words 0..rom_words-1 into ram
// one word per cycle, then gives ram port 1 to the access side
// rom_words must not exceed the ram depth
// ------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module boot_sequencer #(
	parameter int unsigned rom_words = 32,
	parameter int unsigned ram_addr_bits = 9
) (
	input wire logic clock,
	input wire logic reset,

	// rom side
	output logic [mem_pkg::index_bits(rom_words) - 1 : 0] rom_index,
	input mem_pkg::t_word rom_word,

	// ram port 1 owner mux
	input mem_pkg::t_ram_port access_port,
	output mem_pkg::t_ram_port ram_port,

	// high once the copy is done
	output logic run
);

	localparam int unsigned idx_bits = mem_pkg::index_bits(rom_words);

	// image has to fit into the ram
	if (rom_words > 2 ** ram_addr_bits) begin : g_size_check
		$error("rom_words exceeds ram depth");
	end

	ctrl_pkg::t_boot_state state, next_state;
	logic [idx_bits - 1 : 0] copy_index;
	logic copy_last;

	assign copy_last = (copy_index == idx_bits'(rom_words - 1));

	// ------------------------------------------------------------
	// state register and copy counter
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ctrl_pkg::RESET_ALL;
			copy_index <= '0;
		end else begin
			state <= next_state;
			if (state == ctrl_pkg::COPY_ROM && !copy_last)
				copy_index <= copy_index + 1'b1;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			ctrl_pkg::RESET_ALL:
				next_state = ctrl_pkg::COPY_ROM;
			ctrl_pkg::COPY_ROM:
				if (copy_last)
					next_state = ctrl_pkg::RUN_CPU;
			// stays until the next reset
			default: ;
		endcase
	end

	assign run = (state == ctrl_pkg::RUN_CPU);
	assign rom_index = copy_index;

	// ------------------------------------------------------------
	// port 1 owner
	// ------------------------------------------------------------
	always_comb begin
		if (run) begin
			ram_port = access_port;
		end else begin
			// copy side, writes only while copying
			ram_port.write_en = (state == ctrl_pkg::COPY_ROM);
			ram_port.addr = mem_pkg::t_addr'(copy_index);
			ram_port.wdata = rom_word;
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	// each copy cycle writes the word above the previous one, from zero
	a_copy_writes: assert property (@(posedge clock) disable iff (reset)
		state == ctrl_pkg::COPY_ROM |-> ram_port.write_en
			&& ram_port.addr == ($past(state) == ctrl_pkg::COPY_ROM
				? $past(ram_port.addr) + 1'b1 : '0));

	// the full image went in before the cpu got the ram
	a_copy_complete: assert property (@(posedge clock) disable iff (reset)
		$rose(run) |-> $past(state, rom_words) == ctrl_pkg::COPY_ROM
			&& $past(state, rom_words + 1) == ctrl_pkg::RESET_ALL);

endmodule

`default_nettype wire

// File: source/mem_access_ctrl.sv
// ------------------------------------------------------------
// processor memory access controller
// serves one request at a time with fixed wait cycles
// read: ready two cycles after valid is sampled
// write: three ram write cycles, then a read back for ready
// requests are ignored until run is high
// ------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mem_access_ctrl #(
	parameter int unsigned ram_addr_bits = 9,
	parameter mem_pkg::t_addr watch_addr = 16'h1ff
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic run,

	// processor bus
	input mem_pkg::t_cpu_req cpu_req,
	output mem_pkg::t_cpu_rsp cpu_rsp,

	// ram port 1, access side
	output mem_pkg::t_ram_port access_port,
	input mem_pkg::t_word ram_rdata,

	// last word written to the watched address
	output mem_pkg::t_word watch_data
);

	// wait cycles, counted from zero
	localparam logic [1 : 0] read_cycles = 2'd1;
	localparam logic [1 : 0] write_cycles = 2'd2;

	ctrl_pkg::t_access_state state, next_state;
	logic [1 : 0] read_cycle, write_cycle;
	mem_pkg::t_word write_data;
	logic watch_hit;

	// ram aliases above its depth, so the watch compares on the ram address
	assign watch_hit = (cpu_req.addr[ram_addr_bits - 1 : 0]
		== watch_addr[ram_addr_bits - 1 : 0]);

	// ------------------------------------------------------------
	// state and wait counters
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ctrl_pkg::WAIT_MEM;
			read_cycle <= '0;
			write_cycle <= '0;
		end else begin
			state <= next_state;

			if (state != ctrl_pkg::MEM_READY || read_cycle == read_cycles)
				read_cycle <= '0;
			else
				read_cycle <= read_cycle + 1'b1;

			if (state != ctrl_pkg::MEM_WRITE || write_cycle == write_cycles)
				write_cycle <= '0;
			else
				write_cycle <= write_cycle + 1'b1;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			ctrl_pkg::WAIT_MEM:
				if (run && cpu_req.valid)
					next_state = cpu_req.write ? ctrl_pkg::PREPARE_WRITE
						: ctrl_pkg::MEM_READY;
			ctrl_pkg::MEM_READY:
				if (read_cycle == read_cycles)
					next_state = ctrl_pkg::WAIT_MEM;
			ctrl_pkg::PREPARE_WRITE:
				next_state = ctrl_pkg::MEM_WRITE;
			ctrl_pkg::MEM_WRITE:
				// back to read wait, ready then carries the new word
				if (write_cycle == write_cycles)
					next_state = ctrl_pkg::MEM_READY;
			default: ;
		endcase
	end

	// ------------------------------------------------------------
	// write data latch and watch register
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (state == ctrl_pkg::PREPARE_WRITE)
			write_data <= cpu_req.wdata;
	end

	always_ff @(posedge clock) begin
		if (reset)
			watch_data <= '0;
		else if (state == ctrl_pkg::PREPARE_WRITE && watch_hit)
			watch_data <= cpu_req.wdata;
	end

	// ------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------
	assign access_port.write_en = (state == ctrl_pkg::MEM_WRITE);
	assign access_port.addr = cpu_req.addr;
	assign access_port.wdata = write_data;

	// synchronous ram read has settled by the last wait cycle
	assign cpu_rsp.ready = (state == ctrl_pkg::MEM_READY && read_cycle == read_cycles);
	assign cpu_rsp.rdata = ram_rdata;

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	// single ready pulse, two cycles after a read is taken, six after a write
	a_ready_timing: assert property (@(posedge clock) disable iff (reset)
		cpu_rsp.ready |-> !$past(cpu_rsp.ready)
			&& ($past(state == ctrl_pkg::WAIT_MEM && run && cpu_req.valid
				&& !cpu_req.write, 2)
			|| $past(state == ctrl_pkg::WAIT_MEM && run && cpu_req.valid
				&& cpu_req.write, 6)));

	// nothing is served during boot
	a_ready_needs_run: assert property (@(posedge clock) disable iff (reset)
		$rose(cpu_rsp.ready) |-> run);

endmodule

`default_nettype wire

// File: source/cpu_mem_top.sv
// ------------------------------------------------------------
// memory side of the 16-bit processor board
// rom is copied into ram after reset, booted then goes high
// the processor bus is served only while booted is high
// port 2 of the ram monitors watch_addr all the time
// ------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module cpu_mem_top #(
	parameter int unsigned ram_addr_bits = 9,
	parameter int unsigned rom_words = 32,
	parameter mem_pkg::t_addr watch_addr = 16'h1ff
) (
	input wire logic clock,
	input wire logic reset,

	// processor memory bus
	input mem_pkg::t_cpu_req cpu_req,
	output mem_pkg::t_cpu_rsp cpu_rsp,

	output logic booted,
	output mem_pkg::t_word watch_data,
	output mem_pkg::t_word monitor_data
);

	logic [mem_pkg::index_bits(rom_words) - 1 : 0] rom_index;
	mem_pkg::t_word rom_word;
	mem_pkg::t_ram_port access_port, ram_port;
	mem_pkg::t_word ram_rdata;

	rom_image #(
		.rom_words(rom_words)
	) rom_mod (
		.rom_index(rom_index),
		.rom_word(rom_word)
	);

	// port 2 fixed on the watched word
	ram_2port #(
		.ram_addr_bits(ram_addr_bits)
	) ram_mod (
		.clock(clock),
		.port1(ram_port),
		.port1_rdata(ram_rdata),
		.port2_addr(watch_addr[ram_addr_bits - 1 : 0]),
		.port2_rdata(monitor_data)
	);

	boot_sequencer #(
		.rom_words(rom_words),
		.ram_addr_bits(ram_addr_bits)
	) boot_mod (
		.clock(clock),
		.reset(reset),
		.rom_index(rom_index),
		.rom_word(rom_word),
		.access_port(access_port),
		.ram_port(ram_port),
		.run(booted)
	);

	mem_access_ctrl #(
		.ram_addr_bits(ram_addr_bits),
		.watch_addr(watch_addr)
	) access_mod (
		.clock(clock),
		.reset(reset),
		.run(booted),
		.cpu_req(cpu_req),
		.cpu_rsp(cpu_rsp),
		.access_port(access_port),
		.ram_rdata(ram_rdata),
		.watch_data(watch_data)
	);

endmodule

`default_nettype wire

// File: test/tb_cpu_mem.sv
// ------------------------------------------------------------
// testbench for cpu_mem_top with its default parameters
// plays the processor, expected values come from a shadow memory
// preloaded with the rom rule, ram depth 512, watch address 0x1ff
// inputs change 10 ns after the rising edge, outputs read there too
// ------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_mem;

	localparam int rom_words = 32;
	localparam int ram_words = 512;
	localparam mem_pkg::t_addr watch_addr = 16'h1ff;
	localparam int watch_index = int'(watch_addr) % ram_words;
	localparam int ready_limit = 20;
	localparam int reset_test = 5;

	// one processor access and what it should return
	typedef struct packed {
		int test_id;
		logic write;
		mem_pkg::t_addr addr;
		mem_pkg::t_word wdata;
		mem_pkg::t_word exp_rdata;
		mem_pkg::t_word exp_watch;
		mem_pkg::t_word exp_monitor;
		logic check_monitor;
	} t_entry;

	logic clock = 1'b0;
	logic reset = 1'b1;
	mem_pkg::t_cpu_req cpu_req;
	mem_pkg::t_cpu_rsp cpu_rsp;
	logic booted;
	mem_pkg::t_word watch_data, monitor_data;

	// reference model
	mem_pkg::t_word shadow [ram_words];
	bit known [ram_words];
	mem_pkg::t_word watch_model = '0;

	t_entry entries [$];
	bit entries_built = 1'b0;
	integer seed = 32'h48c6;
	int errors = 0;
	int checks = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int current_test = 1;
	string test_names [1 : 5] = '{"boot", "rom read", "watch", "write/read", "reset"};

	cpu_mem_top DUT (
		.clock(clock),
		.reset(reset),
		.cpu_req(cpu_req),
		.cpu_rsp(cpu_rsp),
		.booted(booted),
		.watch_data(watch_data),
		.monitor_data(monitor_data)
	);

	always #50 clock = ~clock;

	// ------------------------------------------------------------
	// reference model and table
	// ------------------------------------------------------------
	// word i of the program image
	function automatic mem_pkg::t_word rom_value(input int i);
		return mem_pkg::t_word'(i * 257) ^ 16'ha500;
	endfunction

	// boot copy puts the image back, words above it untouched
	function automatic void load_rom_model();
		for (int i = 0; i < rom_words; i++) begin
			shadow[i] = rom_value(i);
			known[i] = 1'b1;
		end
	endfunction

	function automatic void add_entry(input int test_id, input logic write,
		input mem_pkg::t_addr addr, input mem_pkg::t_word wdata);
		t_entry e;
		int ram_index;
		// ram ignores the upper address bits
		ram_index = int'(addr) % ram_words;
		if (write) begin
			shadow[ram_index] = wdata;
			known[ram_index] = 1'b1;
			if (ram_index == watch_index)
				watch_model = wdata;
		end
		e.test_id = test_id;
		e.write = write;
		e.addr = addr;
		e.wdata = wdata;
		// a write's ready returns the new word
		e.exp_rdata = shadow[ram_index];
		e.exp_watch = watch_model;
		e.exp_monitor = shadow[watch_index];
		e.check_monitor = known[watch_index];
		entries.push_back(e);
	endfunction

	task automatic build_table();
		mem_pkg::t_addr a;
		mem_pkg::t_addr written [$];
		load_rom_model();
		for (int i = 0; i < rom_words; i++)
			add_entry(2, 1'b0, mem_pkg::t_addr'(i), '0);
		// watched word, then writes elsewhere
		add_entry(3, 1'b1, watch_addr, 16'h5a3c);
		add_entry(3, 1'b0, watch_addr, '0);
		add_entry(3, 1'b1, watch_addr - 16'h1, 16'h1234);
		add_entry(3, 1'b1, 16'h0040, 16'hbeef);
		add_entry(3, 1'b0, watch_addr, '0);
		add_entry(3, 1'b1, watch_addr, 16'hc3a5);
		// two rom words overwritten, one word above the image
		written = '{16'h0003, 16'h0011, 16'h0100};
		foreach (written[k])
			add_entry(4, 1'b1, written[k], mem_pkg::t_word'($random(seed)));
		for (int k = 0; k < 16; k++) begin
			// anything below the watched word
			a = mem_pkg::t_addr'($unsigned($random(seed)) % (ram_words - 1));
			add_entry(4, 1'b1, a, mem_pkg::t_word'($random(seed)));
			add_entry(4, 1'b0, a, '0);
			written.push_back(a);
		end
		// model of the mid-run reset
		load_rom_model();
		watch_model = '0;
		foreach (written[k])
			add_entry(reset_test, 1'b0, written[k], '0);
		add_entry(reset_test, 1'b0, 16'h0000, '0);
		add_entry(reset_test, 1'b0, watch_addr, '0);
	endtask

	// ------------------------------------------------------------
	// checking helpers
	// ------------------------------------------------------------
	task automatic check_value(input string name, input mem_pkg::t_word expected,
		input mem_pkg::t_word actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			test_errors++;
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		test_errors++;
		$display("at %0t: %s", $time, what);
	endtask

	task automatic report_test(input int id);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("test %0d %s: %s, %0d errors", id, test_names[id],
			(test_errors == 0) ? "pass" : "FAIL", test_errors);
		test_errors = 0;
	endtask

	// ------------------------------------------------------------
	// bus actions
	// ------------------------------------------------------------
	// called 10 ns after an edge, right after reset was released
	task automatic wait_boot(input logic with_request);
		int cycles;
		cycles = 0;
		check_value("booted", 16'h0, {15'b0, booted});
		while (!booted && cycles < rom_words + 10) begin
			if (cpu_rsp.ready)
				report_failure("ready was given while the rom was still being copied");
			// early request goes away before booted
			if (with_request && cycles == rom_words - 2)
				cpu_req.valid = 1'b0;
			@(posedge clock);
			#10;
			cycles++;
		end
		if (!booted)
			report_failure("booted did not rise after reset");
		else if (cycles < rom_words || cycles > rom_words + 2)
			report_failure($sformatf("booted rose after %0d cycles", cycles));
		// early request must stay unanswered
		repeat (4) begin
			@(posedge clock);
			#10;
			if (cpu_rsp.ready)
				report_failure("ready answered a request raised before booted");
		end
	endtask

	task automatic apply_reset();
		@(posedge clock);
		#10;
		reset = 1'b1;
		repeat (2) @(posedge clock);
		#10;
		check_value("booted", 16'h0, {15'b0, booted});
		check_value("watch_data", 16'h0, watch_data);
		reset = 1'b0;
		wait_boot(1'b0);
	endtask

	// one request, held until ready, valid dropped the cycle after
	task automatic do_access(input t_entry e);
		int waited;
		logic got_ready;
		mem_pkg::t_word rdata;
		waited = 0;
		got_ready = 1'b0;
		rdata = '0;
		@(posedge clock);
		#10;
		cpu_req.write = e.write;
		cpu_req.addr = e.addr;
		cpu_req.wdata = e.wdata;
		cpu_req.valid = 1'b1;
		while (!got_ready && waited < ready_limit) begin
			@(posedge clock);
			#10;
			waited++;
			if (cpu_rsp.ready) begin
				got_ready = 1'b1;
				rdata = cpu_rsp.rdata;
			end
		end
		if (!got_ready) begin
			report_failure($sformatf("no ready for the access to address %h", e.addr));
		end else begin
			check_value("cpu_rsp.rdata", e.exp_rdata, rdata);
			check_value("watch_data", e.exp_watch, watch_data);
			if (e.check_monitor)
				check_value("monitor_data", e.exp_monitor, monitor_data);
		end
		@(posedge clock);
		#10;
		cpu_req.valid = 1'b0;
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		cpu_req = '0;
		build_table();
		entries_built = 1'b1;
		repeat (2) @(posedge clock);
		#10;
		reset = 1'b0;
		// read raised during the rom copy
		cpu_req.addr = 16'h0005;
		cpu_req.valid = 1'b1;
		wait_boot(1'b1);
		for (int i = 0; i < entries.size(); i++) begin
			if (entries[i].test_id != current_test) begin
				report_test(current_test);
				current_test = entries[i].test_id;
				if (current_test == reset_test)
					apply_reset();
			end
			do_access(entries[i]);
		end
		report_test(current_test);
		$display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// limit from the table length, two boots included
	initial begin
		wait (entries_built);
		repeat (entries.size() * 20 + rom_words + 50) @(posedge clock);
		$display("watchdog: simulation ran past its cycle limit");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
source/mem_pkg.sv
source/ctrl_pkg.sv
source/rom_image.sv
source/ram_2port.sv
source/boot_sequencer.sv
source/mem_access_ctrl.sv
source/cpu_mem_top.sv
test/tb_cpu_mem.sv

// File: Makefile
# Verilator build and run for the cpu memory subsystem

VERILATOR ?= verilator
FILELIST ?= tb.f
TOP ?= tb_cpu_mem
LINT_TOP ?= cpu_mem_top
BUILD_DIR ?= build
LOG ?= sim.log
FAIL_PATTERN ?= Test failed
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

RTL_FILES := $(shell grep '^source/' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_PATTERN)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
